//--- common/fpu_pkg.sv
/*
  fpu subsystem shared definitions
  opcodes, command / result / writeback words and the canonical NaN
*/
package fpu_pkg;

  localparam int unsigned NUM_FREGS = 32;          // fixed by 5-bit register fields
  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000; // positive quiet NaN
  localparam int unsigned FCSR_RM_LSB = 5;          // frm sits at fcsr[7:5]

  // operation codes, values match the pattern file
  typedef enum logic [3:0] {
    OP_LOAD  = 4'd0,
    OP_READ  = 4'd1,
    OP_SGNJ  = 4'd2,
    OP_SGNJN = 4'd3,
    OP_SGNJX = 4'd4,
    OP_MIN   = 4'd5,
    OP_MAX   = 4'd6,
    OP_FEQ   = 4'd7,
    OP_FLT   = 4'd8,
    OP_FLE   = 4'd9,
    OP_SETRM = 4'd10,
    OP_RDCSR = 4'd11
  } fp_op_e;

  typedef struct packed {
    fp_op_e      op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] data; // load value, or new rm in [2:0]
  } fp_cmd_t;

  typedef struct packed {
    logic [31:0] data; // reg value, compare bit or fcsr
    logic [4:0]  rd;   // echo for tracing
  } fp_result_t;

  typedef struct packed {
    logic nv; // invalid
    logic dz; // divide by zero
    logic of; // overflow
    logic uf; // underflow
    logic nx; // inexact
  } fp_flags_t;

  typedef struct packed {
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        flag_en;
    fp_flags_t   flags;
    logic        rm_en;
    logic [2:0]  rm;
  } fp_wb_t;

  // ops that return a word to the consumer and so need a result credit
  function automatic logic fp_has_result(fp_op_e op);
    return (op == OP_READ) || (op == OP_FEQ) || (op == OP_FLT) ||
           (op == OP_FLE) || (op == OP_RDCSR);
  endfunction

endpackage

//--- rtl/fpu_cmd_queue.sv
/*
  fpu command queue
  circular buffer filled under producer credits, one credit back per pop
*/
`timescale 1ns/1ps

module fpu_cmd_queue import fpu_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic    frf_rf,
  input  logic    rst_n,
  input  logic    cmd_valid,
  input  fp_cmd_t cmd,
  input  logic    q_pop,
  output logic    q_valid,
  output fp_cmd_t q_cmd,
  output logic    cmd_credit
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  fp_cmd_t            mem [DEPTH]; // entries, no reset
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;       // occupancy
  logic               push;
  logic               pop;

  assign push = cmd_valid;          // credits guarantee a free slot
  assign pop  = q_pop && q_valid;

  // pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or both
      endcase
    end
  end

  // storage write
  always_ff @(posedge frf_rf) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

  assign q_valid    = (count != '0);
  assign q_cmd      = mem[rd_ptr]; // head
  assign cmd_credit = pop;         // same cycle as the pop

endmodule

//--- fpu_core/fp_exec_unit.sv
/*
  fp execution unit
  exact ops only. sign injection, min/max, compares, load pass-through
*/
`timescale 1ns/1ps

module fp_exec_unit import fpu_pkg::*; (
  input  fp_op_e      op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] wdata,
  output logic [31:0] res,
  output fp_flags_t   flags
);

  logic sa, sb;
  logic a_nan, b_nan;
  logic a_snan, b_snan;
  logic both_zero;
  logic mag_lt, mag_gt;
  logic lt_total;       // -0 below +0, used by min/max
  logic lt_ieee;        // ieee ordering, -0 == +0
  logic eq_ieee;

  assign sa = a[31];
  assign sb = b[31];

  // nan: exponent all ones, mantissa nonzero
  assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != '0);
  assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
  assign a_snan = a_nan && !a[22]; // quiet bit clear
  assign b_snan = b_nan && !b[22];

  assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
  assign mag_lt    = a[30:0] < b[30:0];
  assign mag_gt    = a[30:0] > b[30:0];

  // sign-magnitude ordering
  always_comb begin
    if (sa != sb) lt_total = sa;
    else if (sa)  lt_total = mag_gt; // both negative flips order
    else          lt_total = mag_lt;
  end

  assign lt_ieee = lt_total && !both_zero;
  assign eq_ieee = (a == b) || both_zero;

  always_comb begin
    wdata = a;          // load and default pass a
    res   = a;          // read / rdcsr return a
    flags = '0;
    case (op)
      OP_SGNJ:  wdata = {sb, a[30:0]};
      OP_SGNJN: wdata = {~sb, a[30:0]};
      OP_SGNJX: wdata = {sa ^ sb, a[30:0]};
      OP_MIN, OP_MAX: begin
        if (a_nan && b_nan) wdata = CANON_NAN;
        else if (a_nan)     wdata = b; // single nan yields other
        else if (b_nan)     wdata = a;
        else if (op == OP_MIN) wdata = lt_total ? a : b;
        else                wdata = lt_total ? b : a;
        flags.nv = a_snan || b_snan;
      end
      OP_FEQ: begin
        res      = {31'b0, !a_nan && !b_nan && eq_ieee};
        flags.nv = a_snan || b_snan;   // quiet compare
      end
      OP_FLT: begin
        res      = {31'b0, !a_nan && !b_nan && lt_ieee};
        flags.nv = a_nan || b_nan;     // signaling compare
      end
      OP_FLE: begin
        res      = {31'b0, !a_nan && !b_nan && (lt_ieee || eq_ieee)};
        flags.nv = a_nan || b_nan;
      end
      default: ;
    endcase
  end

endmodule

//--- fpu_core/fp_reg_file.sv
/*
  fp register file
  32 single precision registers, two async read ports, one write port,
  fcsr with rounding mode and accrued exception flags
*/
`timescale 1ns/1ps

module fp_reg_file import fpu_pkg::*; (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  fp_wb_t      wb,
  output logic [31:0] fcsr
);

  logic [31:0] regs [NUM_FREGS];
  logic [2:0]  frm_q;     // rounding mode
  logic [4:0]  fflags_q;  // accrued nv dz of uf nx

  // register array, every entry comes up as canonical nan
  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_FREGS; i++) begin
        regs[i] <= CANON_NAN;
      end
    end else if (wb.wen) begin
      regs[wb.rd] <= wb.wdata;
    end
  end

  // status register
  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      frm_q    <= '0;
      fflags_q <= '0;
    end else begin
      if (wb.rm_en)   frm_q    <= wb.rm;
      if (wb.flag_en) fflags_q <= fflags_q | wb.flags; // sticky
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // frm in [7:5], fflags in [4:0]
  assign fcsr = {{(32 - FCSR_RM_LSB - 3){1'b0}}, frm_q, fflags_q};

endmodule

//--- fpu_core/fp_sequencer.sv
/*
  fp sequencer
  issues queue head one at a time, stalls on hazards and result credits,
  registers writeback and result in a single stage
*/
`timescale 1ns/1ps

module fp_sequencer import fpu_pkg::*; #(
  parameter int unsigned RES_CREDITS = 2
) (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic        q_valid,
  input  fp_cmd_t     q_cmd,
  output logic        q_pop,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [31:0] fcsr,
  output fp_wb_t      wb,
  input  logic        res_credit,
  output logic        res_valid,
  output fp_result_t  result
);

  localparam int unsigned CNT_W = $clog2(RES_CREDITS + 1);

  logic [CNT_W-1:0] res_cnt;       // result credits held
  logic             has_res;
  logic             uses_rs1, uses_rs2;
  logic             wen, flag_en, rm_en;
  logic             hazard;
  logic             issue;
  logic             take;          // issue that consumes a result credit
  logic [31:0]      ex_a;
  logic [31:0]      ex_wdata, ex_res;
  fp_flags_t        ex_flags;

  // writeback / result stage
  logic             wb_wen_q, wb_flag_en_q, wb_rm_en_q;
  logic [4:0]       wb_rd_q;
  logic [31:0]      wb_wdata_q;
  fp_flags_t        wb_flags_q;
  logic [2:0]       wb_rm_q;
  logic             res_valid_q;
  fp_result_t       result_q;

  // opcode decode
  always_comb begin
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    wen      = 1'b0;
    flag_en  = 1'b0;
    rm_en    = 1'b0;
    case (q_cmd.op)
      OP_LOAD:                   wen = 1'b1;
      OP_READ:                   uses_rs1 = 1'b1;
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        wen      = 1'b1;
      end
      OP_MIN, OP_MAX: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        wen      = 1'b1;
        flag_en  = 1'b1;         // snan raises nv
      end
      OP_FEQ, OP_FLT, OP_FLE: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        flag_en  = 1'b1;
      end
      OP_SETRM:                  rm_en = 1'b1;
      default: ;                 // rdcsr touches no register
    endcase
  end

  assign has_res = fp_has_result(q_cmd.op);

  // pending write lands at end of this cycle, operands would be stale
  always_comb begin
    hazard = 1'b0;
    if (wb_wen_q && uses_rs1 && (q_cmd.rs1 == wb_rd_q)) hazard = 1'b1;
    if (wb_wen_q && uses_rs2 && (q_cmd.rs2 == wb_rd_q)) hazard = 1'b1;
    if ((q_cmd.op == OP_RDCSR) && (wb_flag_en_q || wb_rm_en_q)) hazard = 1'b1;
  end

  assign issue = q_valid && !hazard && (!has_res || (res_cnt != '0));
  assign take  = issue && has_res;
  assign q_pop = issue;

  assign rs1 = q_cmd.rs1;
  assign rs2 = q_cmd.rs2;

  // operand a carries load data or fcsr when the op needs them
  always_comb begin
    case (q_cmd.op)
      OP_LOAD:  ex_a = q_cmd.data;
      OP_RDCSR: ex_a = fcsr;
      default:  ex_a = rs1_data;
    endcase
  end

  fp_exec_unit u_exec (
    .op    (q_cmd.op),
    .a     (ex_a),
    .b     (rs2_data),
    .wdata (ex_wdata),
    .res   (ex_res),
    .flags (ex_flags)
  );

  // result credit counter
  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      res_cnt <= CNT_W'(RES_CREDITS);
    end else begin
      case ({res_credit, take})
        2'b10:   res_cnt <= res_cnt + 1'b1; // consumer returned one
        2'b01:   res_cnt <= res_cnt - 1'b1;
        default: res_cnt <= res_cnt;
      endcase
    end
  end

  // stage control
  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q  <= 1'b0;
      wb_wen_q     <= 1'b0;
      wb_flag_en_q <= 1'b0;
      wb_rm_en_q   <= 1'b0;
    end else begin
      res_valid_q  <= take;
      wb_wen_q     <= issue && wen;
      wb_flag_en_q <= issue && flag_en;
      wb_rm_en_q   <= issue && rm_en;
    end
  end

  // stage payload
  always_ff @(posedge frf_rf) begin
    if (issue) begin
      wb_rd_q       <= q_cmd.rd;
      wb_wdata_q    <= ex_wdata;
      wb_flags_q    <= ex_flags;
      wb_rm_q       <= q_cmd.data[2:0]; // new frm for setrm
      result_q.data <= ex_res;
      result_q.rd   <= q_cmd.rd;
    end
  end

  assign wb = '{wen:     wb_wen_q,
                rd:      wb_rd_q,
                wdata:   wb_wdata_q,
                flag_en: wb_flag_en_q,
                flags:   wb_flags_q,
                rm_en:   wb_rm_en_q,
                rm:      wb_rm_q};

  assign res_valid = res_valid_q;
  assign result    = result_q;

endmodule

//--- rtl/fpu_subsystem_top.sv
/*
  fpu register subsystem top
  command queue, sequencer with exec unit, and fp register file
*/
`timescale 1ns/1ps

module fpu_subsystem_top import fpu_pkg::*; #(
  parameter int unsigned CMD_DEPTH   = 4,
  parameter int unsigned RES_CREDITS = 2
) (
  input  logic       frf_rf,
  input  logic       rst_n,
  input  logic       cmd_valid,
  input  fp_cmd_t    cmd,
  output logic       cmd_credit,
  input  logic       res_credit,
  output logic       res_valid,
  output fp_result_t result
);

  logic        q_valid;
  fp_cmd_t     q_cmd;
  logic        q_pop;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] fcsr;
  fp_wb_t      wb;

  fpu_cmd_queue #(.DEPTH(CMD_DEPTH)) u_cmd_queue (
    .frf_rf     (frf_rf),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .q_pop      (q_pop),
    .q_valid    (q_valid),
    .q_cmd      (q_cmd),
    .cmd_credit (cmd_credit)
  );

  fp_sequencer #(.RES_CREDITS(RES_CREDITS)) u_seq (
    .frf_rf     (frf_rf),
    .rst_n      (rst_n),
    .q_valid    (q_valid),
    .q_cmd      (q_cmd),
    .q_pop      (q_pop),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .fcsr       (fcsr),
    .wb         (wb),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .result     (result)
  );

  fp_reg_file u_reg_file (
    .frf_rf   (frf_rf),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .fcsr     (fcsr)
  );

endmodule

//--- dv/fpu_sva.sv
/*
  fpu subsystem assertions
  credit accounting on both loops and res_valid sanity, bound into the top
*/
`timescale 1ns/1ps

module fpu_sva #(
  parameter int unsigned CMD_DEPTH   = 4,
  parameter int unsigned RES_CREDITS = 2
) (
  input logic frf_rf,
  input logic rst_n,
  input logic cmd_valid,
  input logic cmd_credit,
  input logic res_valid,
  input logic res_credit
);

  logic [7:0] q_occ;     // pushed and not yet popped
  logic [7:0] res_avail; // lags the take by a cycle, never below the real count

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      q_occ     <= '0;
      res_avail <= 8'(RES_CREDITS);
    end else begin
      q_occ     <= q_occ + 8'(cmd_valid) - 8'(cmd_credit);
      res_avail <= res_avail + 8'(res_credit) - 8'(res_valid);
    end
  end

  a_queue_bound: assert property (@(posedge frf_rf) disable iff (!rst_n)
    q_occ <= 8'(CMD_DEPTH))
    else $error("command queue occupancy above CMD_DEPTH");

  a_res_credit_bound: assert property (@(posedge frf_rf) disable iff (!rst_n)
    res_avail <= 8'(RES_CREDITS))
    else $error("result credit count above RES_CREDITS");

  a_res_valid_known: assert property (@(posedge frf_rf) disable iff (!rst_n)
    !$isunknown(res_valid))
    else $error("res_valid unknown after reset");

endmodule

bind fpu_subsystem_top fpu_sva #(
  .CMD_DEPTH   (CMD_DEPTH),
  .RES_CREDITS (RES_CREDITS)
) u_sva (
  .frf_rf     (frf_rf),
  .rst_n      (rst_n),
  .cmd_valid  (cmd_valid),
  .cmd_credit (cmd_credit),
  .res_valid  (res_valid),
  .res_credit (res_credit)
);

//--- dv/tb_fpu.sv
/*
  fpu subsystem testbench
  streams the pattern file through the command credit loop, returns
  result credits after random delays and checks results in order
*/
`timescale 1ns/1ps

module tb_fpu import fpu_pkg::*;;

  localparam int unsigned CMD_DEPTH   = 4;
  localparam int unsigned RES_CREDITS = 2;

  logic       frf_rf;
  logic       rst_n;
  logic       cmd_valid;
  fp_cmd_t    cmd;
  logic       cmd_credit;
  logic       res_credit;
  logic       res_valid;
  fp_result_t result;

  fp_cmd_t     pat_cmd[$];     // every command line
  logic [31:0] exp_word[$];    // expected result words in order
  logic [4:0]  exp_rd[$];
  int          credit_due[$];  // cycle at which each result credit goes back
  int          num_pat   = 0;
  int          exp_count = 0;
  int          sent      = 0;
  int          res_idx   = 0;
  int          credits   = CMD_DEPTH; // producer side command credits
  int          errors    = 0;
  int          cyc       = 0;
  int          limit     = 100;
  int          delay;
  integer      seed      = 32'h7dbc;

  fpu_subsystem_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) DUT (
    .frf_rf     (frf_rf),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .result     (result)
  );

  initial begin
    frf_rf = 1'b0;
    forever #2 frf_rf = ~frf_rf; // 4 ns period
  end

  // each line holds op rd rs1 rs2 data expect word
  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op, f_rd, f_rs1, f_rs2, f_data, f_exp, f_word;
    fp_cmd_t     c;
    fd = $fopen("dv/fpu_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file dv/fpu_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != 8'h23) begin // lines starting with # are comments
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      f_op, f_rd, f_rs1, f_rs2, f_data, f_exp, f_word);
          if (n == 7) begin
            c.op   = fp_op_e'(f_op[3:0]);
            c.rd   = f_rd[4:0];
            c.rs1  = f_rs1[4:0];
            c.rs2  = f_rs2[4:0];
            c.data = f_data;
            pat_cmd.push_back(c);
            if (f_exp[0]) begin // line expects a result word
              exp_word.push_back(f_word);
              exp_rd.push_back(f_rd[4:0]);
            end
          end
        end
      end
      $fclose(fd);
    end
    num_pat   = pat_cmd.size();
    exp_count = exp_word.size();
  endtask

  // producer sends one command per cycle while it holds a credit
  task automatic send_commands();
    int i;
    i = 0;
    while (i < num_pat) begin
      @(posedge frf_rf);
      #1;
      if (credits > 0) begin
        cmd_valid = 1'b1;
        cmd       = pat_cmd[i];
        credits--;
        i++;
        sent++;
      end else begin
        cmd_valid = 1'b0; // no credit left until a pop
      end
    end
    @(posedge frf_rf);
    #1;
    cmd_valid = 1'b0;
  endtask

  always @(negedge frf_rf) begin
    if (rst_n && cmd_credit) begin
      assert (credits < CMD_DEPTH)
        else begin
          errors++;
          $display("Command credit returned at %0t with none outstanding", $time);
        end
      credits++; // one entry popped
    end
  end

  // consumer checks in order and returns a credit 0..3 cycles later
  always @(negedge frf_rf) begin
    if (rst_n && res_valid) begin
      assert (res_idx < exp_count)
        else begin
          errors++;
          $display("Extra result %h for rd %0d at %0t, none was expected",
                   result.data, result.rd, $time);
        end
      if (res_idx < exp_count) begin
        assert (result.data === exp_word[res_idx])
          else begin
            errors++;
            $display("Fail %0t: result %0d data %h, expected %h",
                     $time, res_idx, result.data, exp_word[res_idx]);
          end
        assert (result.rd === exp_rd[res_idx])
          else begin
            errors++;
            $display("Fail %0t: result %0d rd %0d, expected %0d",
                     $time, res_idx, result.rd, exp_rd[res_idx]);
          end
      end
      res_idx++;
      delay = $unsigned($random(seed)) % 4;
      credit_due.push_back(cyc + delay);
    end
  end

  // one credit pulse per cycle at most
  always @(posedge frf_rf) begin
    #1;
    if (credit_due.size() > 0 && credit_due[0] <= cyc) begin
      res_credit = 1'b1;
      void'(credit_due.pop_front());
    end else begin
      res_credit = 1'b0;
    end
  end

  always @(posedge frf_rf) begin
    cyc++;
    if (cyc > limit) begin
      $display("Timeout after %0d cycles with %0d of %0d results seen, errors %0d",
               cyc, res_idx, exp_count, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    res_credit = 1'b0;
    load_patterns();
    limit = 40 * num_pat + 100;
    repeat (3) @(posedge frf_rf);
    #1 rst_n = 1'b1;
    send_commands();
    while (res_idx < exp_count) @(posedge frf_rf);
    repeat (8) @(posedge frf_rf); // let credits drain and stray results show
    assert (num_pat > 0)
      else begin
        errors++;
        $display("No patterns were loaded");
      end
    assert (credits == CMD_DEPTH)
      else begin
        errors++;
        $display("Command credits did not all return, holding %0d", credits);
      end
    $display("results %0d of %0d, commands %0d of %0d, errors %0d",
             res_idx, exp_count, sent, num_pat, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/fpu_patterns.txt
# op rd rs1 rs2 data expect word, all fields hex
# expect 1 marks a command whose result word is checked in order
1 03 03 00 00000000 1 7fc00000
1 1f 1f 00 00000000 1 7fc00000
b 00 00 00 00000000 1 00000000
0 01 00 00 3f800000 0 00000000
1 01 01 00 00000000 1 3f800000
0 02 00 00 c0000000 0 00000000
2 03 01 02 00000000 0 00000000
3 04 01 01 00000000 0 00000000
4 05 02 02 00000000 0 00000000
1 03 03 00 00000000 1 bf800000
1 04 04 00 00000000 1 bf800000
1 05 05 00 00000000 1 40000000
0 06 00 00 80000000 0 00000000
0 07 00 00 00000000 0 00000000
5 08 07 06 00000000 0 00000000
6 09 06 07 00000000 0 00000000
5 0a 00 01 00000000 0 00000000
0 0b 00 00 ffc00001 0 00000000
0 0d 00 00 7fc12345 0 00000000
6 0c 0b 0d 00000000 0 00000000
1 08 08 00 00000000 1 80000000
1 09 09 00 00000000 1 00000000
1 0a 0a 00 00000000 1 3f800000
1 0c 0c 00 00000000 1 7fc00000
b 00 00 00 00000000 1 00000000
7 00 01 01 00000000 1 00000001
8 00 02 01 00000000 1 00000001
9 00 01 02 00000000 1 00000000
8 00 06 07 00000000 1 00000000
7 00 06 07 00000000 1 00000001
7 00 00 01 00000000 1 00000000
8 00 00 01 00000000 1 00000000
b 00 00 00 00000000 1 00000010
2 0e 01 02 00000000 0 00000000
1 0e 0e 00 00000000 1 bf800000
a 00 00 00 00000003 0 00000000
b 00 00 00 00000000 1 00000070

//--- sim.f
common/fpu_pkg.sv
rtl/fpu_cmd_queue.sv
fpu_core/fp_exec_unit.sv
fpu_core/fp_reg_file.sv
fpu_core/fp_sequencer.sv
rtl/fpu_subsystem_top.sv
dv/fpu_sva.sv
dv/tb_fpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run tb_fpu with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -f sim.f \
  > build.log 2>&1 \
  && ./obj_dir/Vtb_fpu > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
  || { echo "PASS"; exit 0; }
